/* common/uartPkg.sv */
//////////////////////////////////////////////////
// serial port shared definitions
// frame data width, byte and status types
// status bit positions
// receiver and transmitter state encodings
//////////////////////////////////////////////////

package uartPkg;

	localparam int dataBits = 8;	// 8-bit processor, fixed

	typedef logic [dataBits-1:0] dataByte_t;	// one data byte
	typedef logic [7:0] statusByte_t;	// word returned by the status instruction

	// status bit positions, upper bits read zero
	localparam int rxEmptyBit = 0;
	localparam int rxFullBit = 1;
	localparam int txEmptyBit = 2;
	localparam int txFullBit = 3;

	// receiver states
	typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxState_t;

	// transmitter states
	typedef enum logic [1:0] {txIdle, txStart, txData, txStop} txState_t;

endpackage

/* uart/baudGen.sv */
//////////////////////////////////////////////////
// baud tick generator
// one-cycle sTick every baudDiv clocks
// (16x oversampling rate)
//////////////////////////////////////////////////
`timescale 1ns/1ns

module baudGen #(
	parameter int baudDiv = 4	// clocks per sTick
) (
	input logic clk,
	input logic reset,
	output logic sTick
);

	// at least one bit even for baudDiv of 1
	localparam int cntWidth = (baudDiv > 1) ? $clog2(baudDiv) : 1;
	localparam logic [cntWidth-1:0] cntMax = cntWidth'(baudDiv - 1);

	logic [cntWidth-1:0] cnt;	// clock divider

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			cnt <= '0;
		else if (cnt == cntMax)
			cnt <= '0;	// wrap
		else
			cnt <= cnt + 1'b1;
	end

	assign sTick = (cnt == cntMax);	// pulse on the wrap cycle

endmodule

/* uart/uartRec.sv */
//////////////////////////////////////////////////
// serial receiver
// oversampled start detect, mid-bit sampling,
// LSB-first data, stop period of sbTick ticks
// rxDoneTick pulses with the byte on rxByte
//////////////////////////////////////////////////
`timescale 1ns/1ns

module uartRec import uartPkg::*; #(
	parameter int sbTick = 16	// ticks in stop period, 16 = one stop bit
) (
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic rx,
	output logic rxDoneTick,
	output dataByte_t rxByte
);

	// tick counter must also reach sbTick-1 for long stop periods
	localparam int sWidth = (sbTick > 16) ? $clog2(sbTick) : 4;
	localparam int nWidth = $clog2(dataBits);

	rxState_t stateReg, stateNext;
	logic [sWidth-1:0] sReg, sNext;	// sTick counter
	logic [nWidth-1:0] nReg, nNext;	// data bit counter
	dataByte_t bReg, bNext;	// shift register

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= rxIdle;
			sReg <= '0;
			nReg <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;	// payload only

	//////////////////////////////////////////////////
	// next state logic
	//////////////////////////////////////////////////
	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		rxDoneTick = 1'b0;
		case (stateReg)
			rxIdle:
				if (!rx)	// falling start edge
				begin
					stateNext = rxStart;
					sNext = '0;
				end
			rxStart:
				if (sTick)
				begin
					if (sReg == sWidth'(7))	// middle of start bit
					begin
						stateNext = rxData;
						sNext = '0;
						nNext = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			rxData:
				if (sTick)
				begin
					if (sReg == sWidth'(15))	// middle of next data bit
					begin
						sNext = '0;
						bNext = {rx, bReg[dataBits-1:1]};	// LSB arrives first
						if (nReg == nWidth'(dataBits - 1))
							stateNext = rxStop;	// all bits in
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			rxStop:
				if (sTick)
				begin
					if (sReg == sWidth'(sbTick - 1))
					begin
						stateNext = rxIdle;
						rxDoneTick = 1'b1;	// byte complete
					end
					else
						sNext = sReg + 1'b1;
				end
			default: stateNext = rxIdle;
		endcase
	end

	assign rxByte = bReg;

endmodule

/* uart/uartXmit.sv */
//////////////////////////////////////////////////
// serial transmitter
// pulls a byte from the transmit FIFO,
// sends start bit, LSB-first data, stop period
// registered tx line, txDoneTick at end of stop
//////////////////////////////////////////////////
`timescale 1ns/1ns

module uartXmit import uartPkg::*; #(
	parameter int sbTick = 16	// ticks in stop period
) (
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic txEmpty,	// FIFO level, byte waiting when low
	input dataByte_t txByte,	// FIFO head
	output logic txPop,
	output logic txDoneTick,
	output logic tx
);

	localparam int sWidth = (sbTick > 16) ? $clog2(sbTick) : 4;
	localparam int nWidth = $clog2(dataBits);

	txState_t stateReg, stateNext;
	logic [sWidth-1:0] sReg, sNext;	// sTick counter
	logic [nWidth-1:0] nReg, nNext;	// bits sent
	dataByte_t bReg, bNext;	// outgoing shift register
	logic txReg, txNext;	// line register, no glitches on tx

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= txIdle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;	// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	//////////////////////////////////////////////////
	// next state logic
	//////////////////////////////////////////////////
	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = txReg;
		txPop = 1'b0;
		txDoneTick = 1'b0;
		case (stateReg)
			txIdle:
			begin
				txNext = 1'b1;
				if (!txEmpty)
				begin
					stateNext = txStart;
					sNext = '0;
					bNext = txByte;	// grab head
					txPop = 1'b1;	// and release it
					txNext = 1'b0;	// start bit from next cycle
				end
			end
			txStart:
			begin
				txNext = 1'b0;
				if (sTick)
				begin
					if (sReg == sWidth'(15))
					begin
						stateNext = txData;
						sNext = '0;
						nNext = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			txData:
			begin
				txNext = bReg[0];	// LSB first
				if (sTick)
				begin
					if (sReg == sWidth'(15))
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == nWidth'(dataBits - 1))
							stateNext = txStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			txStop:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == sWidth'(sbTick - 1))
					begin
						stateNext = txIdle;
						txDoneTick = 1'b1;	// frame sent
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			default: stateNext = txIdle;
		endcase
	end

	assign tx = txReg;

endmodule

/* uart/uartFifo.sv */
//////////////////////////////////////////////////
// first-word-fall-through byte FIFO
// depth 2**fifoAddrWidth, full and empty levels
// write when full and read when empty ignored
//////////////////////////////////////////////////
`timescale 1ns/1ns

module uartFifo import uartPkg::*; #(
	parameter int fifoAddrWidth = 2	// log2 of depth
) (
	input logic clk,
	input logic reset,
	input logic wr,
	input logic rd,
	input dataByte_t wrData,
	output dataByte_t rdData,
	output logic full,
	output logic empty
);

	localparam int depth = 2 ** fifoAddrWidth;

	dataByte_t mem [depth];	// storage, no reset
	logic [fifoAddrWidth-1:0] wrPtr, rdPtr;
	logic [fifoAddrWidth:0] count;	// one extra bit to hold depth
	logic wrEn, rdEn;

	assign wrEn = wr && !full;	// drop on full
	assign rdEn = rd && !empty;	// ignore on empty

	always_ff @(posedge clk)
		if (wrEn)
			mem[wrPtr] <= wrData;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (wrEn)
				wrPtr <= wrPtr + 1'b1;	// wraps at depth
			if (rdEn)
				rdPtr <= rdPtr + 1'b1;
			case ({wrEn, rdEn})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// none or both
			endcase
		end
	end

	assign rdData = mem[rdPtr];	// head always visible
	assign full = (count == (fifoAddrWidth+1)'(depth));
	assign empty = (count == '0);

endmodule

/* design/uartPeriph.sv */
//////////////////////////////////////////////////
// serial port peripheral top level
// baud generator, receiver, transmitter,
// receive and transmit FIFOs, status byte
//////////////////////////////////////////////////
`timescale 1ns/1ns

module uartPeriph import uartPkg::*; #(
	parameter int baudDiv = 4,	// clocks per sTick
	parameter int sbTick = 16,	// stop period in sTicks
	parameter int fifoAddrWidth = 2	// FIFO depth 4
) (
	input logic clk,
	input logic reset,
	input logic wrStrobe,	// write instruction
	input dataByte_t wrData,
	input logic rdStrobe,	// read instruction, pops receive FIFO
	output dataByte_t rdData,
	output statusByte_t status,
	input logic rx,
	output logic tx
);

	logic sTick;
	logic rxDoneTick;
	dataByte_t rxByte;
	logic rxFull, rxEmpty;
	logic txPop;
	dataByte_t txByte;
	logic txFull, txEmpty;

	baudGen #(.baudDiv(baudDiv)) baudGen0 (
		.clk(clk),
		.reset(reset),
		.sTick(sTick)
	);

	//////////////////////////////////////////////////
	// receive path
	//////////////////////////////////////////////////
	uartRec #(.sbTick(sbTick)) uartRec0 (
		.clk(clk),
		.reset(reset),
		.sTick(sTick),
		.rx(rx),
		.rxDoneTick(rxDoneTick),
		.rxByte(rxByte)
	);

	uartFifo #(.fifoAddrWidth(fifoAddrWidth)) rxFifo (
		.clk(clk),
		.reset(reset),
		.wr(rxDoneTick),	// each finished frame
		.rd(rdStrobe),
		.wrData(rxByte),
		.rdData(rdData),
		.full(rxFull),
		.empty(rxEmpty)
	);

	//////////////////////////////////////////////////
	// transmit path
	//////////////////////////////////////////////////
	uartFifo #(.fifoAddrWidth(fifoAddrWidth)) txFifo (
		.clk(clk),
		.reset(reset),
		.wr(wrStrobe),
		.rd(txPop),	// transmitter takes the head
		.wrData(wrData),
		.rdData(txByte),
		.full(txFull),
		.empty(txEmpty)
	);

	uartXmit #(.sbTick(sbTick)) uartXmit0 (
		.clk(clk),
		.reset(reset),
		.sTick(sTick),
		.txEmpty(txEmpty),
		.txByte(txByte),
		.txPop(txPop),
		.txDoneTick(),	// end of frame, processor polls status instead
		.tx(tx)
	);

	// status word for the status instruction
	always_comb
	begin
		status = '0;	// upper bits read zero
		status[rxEmptyBit] = rxEmpty;
		status[rxFullBit] = rxFull;
		status[txEmptyBit] = txEmpty;
		status[txFullBit] = txFull;
	end

endmodule

/* tests/uartPeriphTb.sv */
//////////////////////////////////////////////////
// testbench for the serial port peripheral
// clock, reset, LFSR byte source, tx to rx loopback
// status, FIFO order, overflow and empty-read checks
//////////////////////////////////////////////////
`timescale 1ns/1ns

module uartPeriphTb import uartPkg::*; ();

	localparam int baudDiv = 4;	// dut default
	localparam int frameCycles = 10 * 16 * baudDiv;	// start, 8 data, stop
	localparam int timeoutCycles = 20 * frameCycles;

	logic clk;
	logic reset;
	logic wrStrobe;
	logic rdStrobe;
	dataByte_t wrData;
	dataByte_t rdData;
	statusByte_t status;
	logic serial;	// tx looped back to rx

	logic [15:0] lfsr;	// random source state
	dataByte_t expected[$];	// bytes still to come back
	dataByte_t newByte;
	statusByte_t prevStatus;
	dataByte_t prevData;

	uartPeriph dut0 (
		.clk(clk),
		.reset(reset),
		.wrStrobe(wrStrobe),
		.wrData(wrData),
		.rdStrobe(rdStrobe),
		.rdData(rdData),
		.status(status),
		.rx(serial),
		.tx(serial)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	// 16-bit Galois LFSR, one step
	function automatic logic [15:0] lfsrStep(input logic [15:0] state);
		if (state[0])
			return (state >> 1) ^ 16'hB400;
		else
			return state >> 1;
	endfunction

	// one step per bit taken
	task automatic randomByte(output dataByte_t value);
		for (int i = 0; i < dataBits; i++)
		begin
			lfsr = lfsrStep(lfsr);
			value[i] = lfsr[0];
		end
	endtask

	task automatic checkEqual(input string name, input logic [7:0] got,
		input logic [7:0] want);
		assert (got === want)
		else
		begin
			$display("Error: %s is %h, expected %h", name, got, want);
			$display("*** FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	// poll one status bit at falling edges
	task automatic waitForStatus(input int bitPos, input logic level, input string what);
		int cycles;
		cycles = 0;
		while (status[bitPos] !== level)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > timeoutCycles)
			begin
				$display("timed out waiting for %s", what);
				$display("*** FAILED ***");
				$fatal(1, "wait timeout");
			end
		end
	endtask

	task automatic writeByte(input dataByte_t value);
		wrData = value;
		wrStrobe = 1'b1;
		@(negedge clk);
		wrStrobe = 1'b0;
	endtask

	// head must match, then pop it
	task automatic readByte(input dataByte_t want);
		checkEqual("rdData", rdData, want);
		rdStrobe = 1'b1;
		@(negedge clk);
		rdStrobe = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////
	initial
	begin
		reset = 1'b1;
		wrStrobe = 1'b0;
		rdStrobe = 1'b0;
		wrData = '0;
		lfsr = 16'd48;	// seed
		repeat (5) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		// idle port after reset
		checkEqual("status", status, 8'h05);	// rxEmpty and txEmpty
		checkEqual("tx", {7'b0, serial}, 8'h01);

		// single byte through the loop
		randomByte(newByte);
		writeByte(newByte);
		waitForStatus(rxEmptyBit, 1'b0, "single byte to arrive");
		readByte(newByte);
		checkEqual("status", status, 8'h05);

		// four bytes back to back
		for (int i = 0; i < 4; i++)
		begin
			randomByte(newByte);
			expected.push_back(newByte);
			writeByte(newByte);
		end
		for (int i = 0; i < 4; i++)
		begin
			waitForStatus(rxEmptyBit, 1'b0, "burst byte to arrive");
			readByte(expected.pop_front());
		end
		checkEqual("status", status, 8'h05);

		// transmitter still finishing its stop bit
		repeat (frameCycles) @(negedge clk);

		// five writes, one popped by the transmitter, rest fill the FIFO
		for (int i = 0; i < 5; i++)
		begin
			randomByte(newByte);
			if (i < 4)
				expected.push_back(newByte);	// fifth lost later at rx FIFO
			writeByte(newByte);
			if (i == 3)
				checkEqual("status", status, 8'h01);	// first already popped, three held
		end
		checkEqual("status", status, 8'h09);	// txFull, nothing received yet
		randomByte(newByte);
		writeByte(newByte);	// sixth, dropped at full tx FIFO
		checkEqual("status", status, 8'h09);

		// let everything drain into the receive side unread
		waitForStatus(txEmptyBit, 1'b1, "transmit FIFO to empty");
		repeat (frameCycles) @(negedge clk);	// last frame lands
		checkEqual("status", status, 8'h06);	// rxFull and txEmpty
		for (int i = 0; i < 4; i++)
			readByte(expected.pop_front());
		checkEqual("status", status, 8'h05);	// fifth byte never stored

		// read of an empty receive FIFO
		prevStatus = status;
		prevData = rdData;
		rdStrobe = 1'b1;
		@(negedge clk);
		rdStrobe = 1'b0;
		@(negedge clk);
		checkEqual("status", status, prevStatus);
		checkEqual("rdData", rdData, prevData);
		checkEqual("tx", {7'b0, serial}, 8'h01);	// line back at idle

		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* uartPeriph.f */
common/uartPkg.sv
uart/baudGen.sv
uart/uartRec.sv
uart/uartXmit.sv
uart/uartFifo.sv
design/uartPeriph.sv
tests/uartPeriphTb.sv

/* run.sh */
#!/usr/bin/env bash
# compile the serial port testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	-f uartPeriph.f --top-module uartPeriphTb -o uartPeriphSim; then
	echo "verilator build failed"
	exit 1
fi

simOutput=$(./obj_dir/uartPeriphSim)
simStatus=$?
echo "$simOutput"

if [ "$simStatus" -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOutput" | grep -qF '*** PASSED ***'; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
